// File: dv/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model #(
    parameter icache_pkg::data_t data_pattern = 32'h5ca1ab1e,
    parameter int unsigned       seed_init    = 32'h8d31407a,
    parameter int                wait_limit   = 200
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             mem_arvalid,
    output logic                             mem_arready,
    input  icache_pkg::addr_t                mem_araddr,
    input  logic [icache_pkg::len_width-1:0] mem_arlen,
    input  logic [1:0]                       mem_arburst,
    input  logic [2:0]                       mem_arsize,
    output logic                             mem_rvalid,
    input  logic                             mem_rready,
    output icache_pkg::data_t                mem_rdata,
    output logic                             mem_rlast,
    // Last accepted request
    output int                               req_count,
    output icache_pkg::addr_t                req_addr,
    output logic [icache_pkg::len_width-1:0] req_len,
    output logic [1:0]                       req_burst,
    output logic [2:0]                       req_size
);

    import icache_pkg::*;

    integer seed;

    // One request, address phase then every beat of the burst
    task automatic serve_request();
        int    wait_cycles;
        int    beat;
        addr_t beat_addr;
        wait_cycles = int'($unsigned($random(seed)) % 4);
        repeat (wait_cycles) @(negedge clock);
        mem_arready = 1'b1;
        @(posedge clock);
        req_addr  = mem_araddr;
        req_len   = mem_arlen;
        req_burst = mem_arburst;
        req_size  = mem_arsize;
        req_count = req_count + 1;
        @(negedge clock);
        mem_arready = 1'b0;
        beat_addr = req_addr;
        for (beat = 0; beat <= int'(req_len); beat++) begin
            wait_cycles = int'($unsigned($random(seed)) % 3);
            repeat (wait_cycles) @(negedge clock);
            mem_rvalid = 1'b1;
            mem_rdata  = beat_addr ^ data_pattern;
            mem_rlast  = (beat == int'(req_len));
            // A stalled beat is dropped here and the fetch side times out
            wait_cycles = 0;
            do begin
                @(posedge clock);
                wait_cycles++;
            end while (!mem_rready && wait_cycles < wait_limit);
            @(negedge clock);
            mem_rvalid = 1'b0;
            mem_rlast  = 1'b0;
            if (req_burst == burst_incr) begin
                beat_addr = beat_addr + 32'd4;
            end
        end
    endtask

    initial begin
        seed        = seed_init;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        mem_rlast   = 1'b0;
        req_count   = 0;
        req_addr    = '0;
        req_len     = '0;
        req_burst   = '0;
        req_size    = '0;
        forever begin
            @(negedge clock);
            if (!reset && mem_arvalid) begin
                serve_request();
            end
        end
    end

endmodule

// File: dv/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    import icache_pkg::*;

    localparam int cache_words_log2  = 2;
    localparam int cache_index_width = 3;
    localparam int cache_lines       = 2 ** cache_index_width;
    localparam int line_shift        = word_offset_width + cache_words_log2;
    localparam int tag_shift         = line_shift + cache_index_width;
    localparam data_t data_pattern   = 32'h5ca1ab1e;
    localparam int fetch_count       = 300;
    localparam int wait_limit        = 200;

    logic                 clock;
    logic                 reset;
    logic                 fetch_arvalid;
    logic                 fetch_arready;
    addr_t                fetch_araddr;
    logic                 fetch_rvalid;
    logic                 fetch_rready;
    data_t                fetch_rdata;
    logic                 fetch_rlast;
    logic                 mem_arvalid;
    logic                 mem_arready;
    addr_t                mem_araddr;
    logic [len_width-1:0] mem_arlen;
    logic [1:0]           mem_arburst;
    logic [2:0]           mem_arsize;
    logic                 mem_rvalid;
    logic                 mem_rready;
    data_t                mem_rdata;
    logic                 mem_rlast;
    logic [31:0]          hit_count;
    logic [31:0]          miss_count;
    logic [31:0]          bypass_count;
    int                   req_count;
    addr_t                req_addr;
    logic [len_width-1:0] req_len;
    logic [1:0]           req_burst;
    logic [2:0]           req_size;

    integer seed;

    // Reference tag table and event counts
    addr_t model_tag [cache_lines];
    logic  model_valid [cache_lines];
    int    model_hits;
    int    model_misses;
    int    model_bypasses;
    int    model_requests;

    always #5 clock = ~clock;

    icache_top #(
        .line_words_log2 (cache_words_log2),
        .index_width     (cache_index_width)
    ) u_dut (
        .clock, .reset,
        .fetch_arvalid, .fetch_arready, .fetch_araddr,
        .fetch_rvalid, .fetch_rready, .fetch_rdata, .fetch_rlast,
        .mem_arvalid, .mem_arready, .mem_araddr, .mem_arlen, .mem_arburst, .mem_arsize,
        .mem_rvalid, .mem_rready, .mem_rdata, .mem_rlast,
        .hit_count, .miss_count, .bypass_count
    );

    icache_mem_model #(
        .data_pattern (data_pattern),
        .seed_init    (32'h8d31407a),
        .wait_limit   (wait_limit)
    ) u_mem (
        .clock, .reset,
        .mem_arvalid, .mem_arready, .mem_araddr, .mem_arlen, .mem_arburst, .mem_arsize,
        .mem_rvalid, .mem_rready, .mem_rdata, .mem_rlast,
        .req_count, .req_addr, .req_len, .req_burst, .req_size
    );

    // --------------------
    // Compare tasks
    // --------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_burst(input logic [len_width-1:0] got_len, input logic [1:0] got_burst,
                               input logic [2:0] got_size, input logic [len_width-1:0] exp_len,
                               input logic [1:0] exp_burst, input logic [2:0] exp_size);
        if (got_len !== exp_len || got_burst !== exp_burst || got_size !== exp_size) begin
            report_failure($sformatf(
                "Mismatch at %0t: mem_arlen/arburst/arsize got %0d/%b/%b expected %0d/%b/%b",
                $time, got_len, got_burst, got_size, exp_len, exp_burst, exp_size));
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------
    function automatic int unsigned random_below(input int unsigned bound);
        return $unsigned($random(seed)) % bound;
    endfunction

    // Three tags over four indexes gives plenty of conflict evictions
    function automatic addr_t pick_address();
        addr_t addr;
        if (random_below(4) == 0) begin
            addr = $random(seed);
            addr[31:28] = 4'h4;
            addr[1:0] = 2'b00;
        end else begin
            addr = {cacheable_prefix, 24'h0};
            addr = addr | (addr_t'(random_below(3)) << tag_shift);
            addr = addr | (addr_t'(random_below(4)) << line_shift);
            addr = addr | (addr_t'(random_below(4)) << word_offset_width);
        end
        return addr;
    endfunction

    task automatic run_fetch(input addr_t addr);
        int    cycles;
        int    latency;
        int    idx;
        logic  seen;
        logic  done;
        logic  cacheable;
        logic  expect_hit;
        logic  got_last;
        addr_t tag;
        data_t first_data;
        data_t got_data;
        cacheable  = (addr[31:24] == cacheable_prefix);
        idx        = int'(addr[line_shift +: cache_index_width]);
        tag        = addr >> tag_shift;
        expect_hit = cacheable && model_valid[idx] && (model_tag[idx] == tag);
        latency    = 0;
        seen       = 1'b0;
        done       = 1'b0;
        got_last   = 1'b0;
        first_data = '0;
        got_data   = '0;

        @(negedge clock);
        fetch_arvalid = 1'b1;
        fetch_araddr  = addr;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > wait_limit) begin
                report_failure("Timeout: the cache never accepted the fetch address");
            end
        end while (!fetch_arready);

        // Reply with random back-pressure, data must hold while stalled
        cycles = 0;
        while (!done) begin
            @(negedge clock);
            fetch_arvalid = 1'b0;
            fetch_rready  = (random_below(3) != 0);
            @(posedge clock);
            cycles++;
            if (cycles > wait_limit) begin
                report_failure("Timeout: no fetch reply was transferred");
            end
            if (seen && !fetch_rvalid) begin
                report_failure("fetch_rvalid dropped before the reply was transferred");
            end
            if (fetch_rvalid) begin
                if (!seen) begin
                    seen       = 1'b1;
                    latency    = cycles;
                    first_data = fetch_rdata;
                end else begin
                    check_data("fetch_rdata while stalled", fetch_rdata, first_data);
                end
                if (fetch_rready) begin
                    done     = 1'b1;
                    got_data = fetch_rdata;
                    got_last = fetch_rlast;
                end
            end
        end

        check_data("fetch_rdata", got_data, addr ^ data_pattern);
        check_count("fetch_rlast", 32'(got_last), 32'd1);

        if (!cacheable) begin
            model_bypasses++;
            model_requests++;
            check_count("memory request count", req_count, model_requests);
            check_addr("mem_araddr", req_addr, addr);
            check_burst(req_len, req_burst, req_size, '0, burst_fixed, size_word);
        end else if (expect_hit) begin
            model_hits++;
            check_count("memory request count", req_count, model_requests);
            check_count("hit reply latency", latency, 32'd2);
        end else begin
            model_misses++;
            model_requests++;
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
            check_count("memory request count", req_count, model_requests);
            check_addr("mem_araddr", req_addr, addr & ~((addr_t'(1) << line_shift) - 1));
            check_burst(req_len, req_burst, req_size,
                        len_width'((1 << cache_words_log2) - 1), burst_incr, size_word);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        fetch_arvalid = 1'b0;
        fetch_araddr  = '0;
        fetch_rready  = 1'b0;
        seed          = 32'h8d31407a;
        model_hits     = 0;
        model_misses   = 0;
        model_bypasses = 0;
        model_requests = 0;
        for (int i = 0; i < cache_lines; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end

        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int n = 0; n < fetch_count; n++) begin
            run_fetch(pick_address());
        end

        @(negedge clock);
        check_count("hit_count", hit_count, model_hits);
        check_count("miss_count", miss_count, model_misses);
        check_count("bypass_count", bypass_count, model_bypasses);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: list.f
logic/icache_pkg.sv
logic/icache_line_store.sv
logic/icache_ctrl.sv
logic/icache_perf_counters.sv
logic/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv

// File: logic/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int line_words_log2 = icache_pkg::line_words_log2,
    parameter int index_width     = icache_pkg::index_width
) (
    input  logic                           clock,
    input  logic                           reset,
    // Fetch side
    input  logic                           fetch_arvalid,
    output logic                           fetch_arready,
    input  icache_pkg::addr_t              fetch_araddr,
    output logic                           fetch_rvalid,
    input  logic                           fetch_rready,
    output icache_pkg::data_t              fetch_rdata,
    output logic                           fetch_rlast,
    // Memory side
    output logic                           mem_arvalid,
    input  logic                           mem_arready,
    output icache_pkg::addr_t              mem_araddr,
    output logic [icache_pkg::len_width-1:0] mem_arlen,
    output logic [1:0]                     mem_arburst,
    output logic [2:0]                     mem_arsize,
    input  logic                           mem_rvalid,
    output logic                           mem_rready,
    input  icache_pkg::data_t              mem_rdata,
    input  logic                           mem_rlast,
    // Line store
    output logic [index_width-1:0]         lookup_index,
    output logic [icache_pkg::addr_width - icache_pkg::word_offset_width
                  - line_words_log2 - index_width - 1:0] lookup_tag,
    output logic                           fill_start,
    output logic                           fill_beat_valid,
    output icache_pkg::data_t              fill_data,
    output logic [line_words_log2-1:0]     read_word,
    input  logic                           lookup_hit,
    input  icache_pkg::data_t              read_data,
    // Performance events
    output logic                           hit_event,
    output logic                           miss_event,
    output logic                           bypass_event
);

    import icache_pkg::*;

    localparam int tag_width   = addr_width - word_offset_width - line_words_log2 - index_width;
    localparam int line_words  = 2 ** line_words_log2;
    localparam int line_offset = word_offset_width + line_words_log2;

    localparam logic [2:0] st_idle        = 3'd0;
    localparam logic [2:0] st_lookup      = 3'd1;
    localparam logic [2:0] st_hit_reply   = 3'd2;
    localparam logic [2:0] st_miss_refill = 3'd3;
    localparam logic [2:0] st_bypass      = 3'd4;

    logic [2:0] state;
    logic [2:0] state_next;
    addr_t      req_addr;
    addr_t      line_addr;
    logic       fetch_accept;
    logic       fetch_cacheable;
    logic       refill_done;
    logic       bypass_done;

    assign fetch_arready   = (state == st_idle);
    assign fetch_accept    = fetch_arvalid && fetch_arready;
    assign fetch_cacheable = (fetch_araddr[addr_width-1 -: $bits(cacheable_prefix)]
                              == cacheable_prefix);

    // Held for the whole fetch including the reply
    always_ff @(posedge clock) begin
        if (fetch_accept) begin
            req_addr <= fetch_araddr;
        end
    end

    // --------------------
    // Address fields
    // --------------------
    assign lookup_tag   = req_addr[addr_width-1 -: tag_width];
    assign lookup_index = req_addr[line_offset +: index_width];
    assign read_word    = req_addr[word_offset_width +: line_words_log2];
    assign line_addr    = {req_addr[addr_width-1:line_offset], {line_offset{1'b0}}};

    // --------------------
    // State machine
    // --------------------
    assign refill_done = (state == st_miss_refill) && mem_rvalid && mem_rlast;
    assign bypass_done = (state == st_bypass) && mem_rvalid && fetch_rready && mem_rlast;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (fetch_accept) begin
                    state_next = fetch_cacheable ? st_lookup : st_bypass;
                end
            end
            st_lookup: begin
                state_next = lookup_hit ? st_hit_reply : st_miss_refill;
            end
            st_hit_reply: begin
                if (fetch_rready) begin
                    state_next = st_idle;
                end
            end
            st_miss_refill: begin
                // Reply from the line once the last beat is written
                if (refill_done) begin
                    state_next = st_hit_reply;
                end
            end
            st_bypass: begin
                if (bypass_done) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // --------------------
    // Memory request
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mem_arvalid <= 1'b0;
        end else if ((fetch_accept && !fetch_cacheable) || fill_start) begin
            mem_arvalid <= 1'b1;
        end else if (mem_arready) begin
            mem_arvalid <= 1'b0;
        end
    end

    // Refill starts at word 0 of the line and bypass keeps the exact address
    assign mem_araddr  = (state == st_bypass) ? req_addr : line_addr;
    assign mem_arlen   = (state == st_bypass) ? '0 : len_width'(line_words - 1);
    assign mem_arburst = (state == st_bypass) ? burst_fixed : burst_incr;
    assign mem_arsize  = size_word;
    assign mem_rready  = (state == st_miss_refill) || ((state == st_bypass) && fetch_rready);

    // --------------------
    // Line store and reply
    // --------------------
    assign fill_start      = (state == st_lookup) && !lookup_hit;
    assign fill_beat_valid = (state == st_miss_refill) && mem_rvalid;
    assign fill_data       = mem_rdata;

    // Bypass beats are forwarded straight through
    assign fetch_rvalid = (state == st_hit_reply) || ((state == st_bypass) && mem_rvalid);
    assign fetch_rdata  = (state == st_bypass) ? mem_rdata : read_data;
    assign fetch_rlast  = (state == st_hit_reply) || ((state == st_bypass) && mem_rlast);

    assign hit_event    = (state == st_lookup) && lookup_hit;
    assign miss_event   = fill_start;
    assign bypass_event = (state == st_bypass) && mem_arvalid && mem_arready;

    a_araddr_stable: assert property (@(posedge clock) disable iff (reset)
        (mem_arvalid && !mem_arready) |=> (mem_arvalid && $stable(mem_araddr)));

    // No reply can rise in the cycle that leaves idle
    a_no_rvalid_after_idle: assert property (@(posedge clock) disable iff (reset)
        (state == st_idle) |=> !fetch_rvalid);

endmodule

// File: logic/icache_line_store.sv
`timescale 1ns/1ps

module icache_line_store #(
    parameter int line_words_log2 = icache_pkg::line_words_log2,
    parameter int index_width     = icache_pkg::index_width
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [index_width-1:0]     lookup_index,
    input  logic [icache_pkg::addr_width - icache_pkg::word_offset_width
                  - line_words_log2 - index_width - 1:0] lookup_tag,
    input  logic                       fill_start,
    input  logic                       fill_beat_valid,
    input  icache_pkg::data_t          fill_data,
    input  logic [line_words_log2-1:0] read_word,
    output logic                       lookup_hit,
    output icache_pkg::data_t          read_data
);

    import icache_pkg::*;

    localparam int tag_width  = addr_width - word_offset_width - line_words_log2 - index_width;
    localparam int line_count = 2 ** index_width;
    localparam int line_words = 2 ** line_words_log2;

    logic [line_count-1:0]  valid_bits;
    logic [tag_width-1:0]   tag_mem [line_count];
    data_t                  data_mem [line_count * line_words];

    // One extra bit so an overrun beat is visible
    logic [line_words_log2:0] fill_count;

    // --------------------
    // Lookup
    // --------------------
    assign lookup_hit = valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign read_data  = data_mem[{lookup_index, read_word}];

    // --------------------
    // Refill
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill_start) begin
            valid_bits[lookup_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fill_count <= '0;
        end else if (fill_start) begin
            fill_count <= '0;
        end else if (fill_beat_valid) begin
            fill_count <= fill_count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_start) begin
            tag_mem[lookup_index] <= lookup_tag;
        end
    end

    // Beats land in order starting at word 0 of the line
    always_ff @(posedge clock) begin
        if (fill_beat_valid) begin
            data_mem[{lookup_index, fill_count[line_words_log2-1:0]}] <= fill_data;
        end
    end

    // Refill burst never delivers more beats than one line holds
    a_fill_within_line: assert property (@(posedge clock) disable iff (reset)
        fill_beat_valid |-> (fill_count < line_words));

endmodule

// File: logic/icache_perf_counters.sv
`timescale 1ns/1ps

module icache_perf_counters (
    input  logic        clock,
    input  logic        reset,
    input  logic        hit_event,
    input  logic        miss_event,
    input  logic        bypass_event,
    output logic [31:0] hit_count,
    output logic [31:0] miss_count,
    output logic [31:0] bypass_count
);

    // --------------------
    // Event counters
    // --------------------
    // Free running, wrap at 2**32
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hit_count    <= '0;
            miss_count   <= '0;
            bypass_count <= '0;
        end else begin
            if (hit_event) begin
                hit_count <= hit_count + 32'd1;
            end
            if (miss_event) begin
                miss_count <= miss_count + 32'd1;
            end
            if (bypass_event) begin
                bypass_count <= bypass_count + 32'd1;
            end
        end
    end

    // Each fetch is classified exactly once
    a_single_event: assert property (@(posedge clock) disable iff (reset)
        $onehot0({hit_event, miss_event, bypass_event}));

endmodule

// File: logic/icache_pkg.sv
package icache_pkg;

    // --------------------
    // Word and address widths
    // --------------------
    localparam int addr_width = 32;
    localparam int data_width = 32;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;

    // Byte offset bits inside one instruction word
    localparam int word_offset_width = 2;

    // --------------------
    // Read address channel encodings
    // --------------------
    localparam int len_width = 8;

    localparam logic [1:0] burst_fixed = 2'b00;
    localparam logic [1:0] burst_incr  = 2'b01;

    // Four bytes per beat
    localparam logic [2:0] size_word = 3'b010;

    // --------------------
    // Memory map
    // --------------------
    // Fetches with address bits 31:24 equal to this go through the cache
    localparam logic [7:0] cacheable_prefix = 8'ha0;

    // --------------------
    // Default cache geometry
    // --------------------
    // Four words per line, eight lines
    localparam int line_words_log2 = 2;
    localparam int index_width     = 3;

endpackage

// File: logic/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int line_words_log2 = icache_pkg::line_words_log2,
    parameter int index_width     = icache_pkg::index_width
) (
    input  logic                             clock,
    input  logic                             reset,
    // Fetch side
    input  logic                             fetch_arvalid,
    output logic                             fetch_arready,
    input  icache_pkg::addr_t                fetch_araddr,
    output logic                             fetch_rvalid,
    input  logic                             fetch_rready,
    output icache_pkg::data_t                fetch_rdata,
    output logic                             fetch_rlast,
    // Memory side
    output logic                             mem_arvalid,
    input  logic                             mem_arready,
    output icache_pkg::addr_t                mem_araddr,
    output logic [icache_pkg::len_width-1:0] mem_arlen,
    output logic [1:0]                       mem_arburst,
    output logic [2:0]                       mem_arsize,
    input  logic                             mem_rvalid,
    output logic                             mem_rready,
    input  icache_pkg::data_t                mem_rdata,
    input  logic                             mem_rlast,
    // Counters
    output logic [31:0]                      hit_count,
    output logic [31:0]                      miss_count,
    output logic [31:0]                      bypass_count
);

    import icache_pkg::*;

    localparam int tag_width = addr_width - word_offset_width - line_words_log2 - index_width;

    logic [index_width-1:0]     lookup_index;
    logic [tag_width-1:0]       lookup_tag;
    logic                       fill_start;
    logic                       fill_beat_valid;
    data_t                      fill_data;
    logic [line_words_log2-1:0] read_word;
    logic                       lookup_hit;
    data_t                      read_data;
    logic                       hit_event;
    logic                       miss_event;
    logic                       bypass_event;

    icache_ctrl #(
        .line_words_log2 (line_words_log2),
        .index_width     (index_width)
    ) u_ctrl (
        .clock, .reset,
        .fetch_arvalid, .fetch_arready, .fetch_araddr,
        .fetch_rvalid, .fetch_rready, .fetch_rdata, .fetch_rlast,
        .mem_arvalid, .mem_arready, .mem_araddr, .mem_arlen, .mem_arburst, .mem_arsize,
        .mem_rvalid, .mem_rready, .mem_rdata, .mem_rlast,
        .lookup_index, .lookup_tag, .fill_start, .fill_beat_valid, .fill_data,
        .read_word, .lookup_hit, .read_data,
        .hit_event, .miss_event, .bypass_event
    );

    icache_line_store #(
        .line_words_log2 (line_words_log2),
        .index_width     (index_width)
    ) u_line_store (
        .clock, .reset,
        .lookup_index, .lookup_tag, .fill_start, .fill_beat_valid, .fill_data,
        .read_word, .lookup_hit, .read_data
    );

    icache_perf_counters u_perf_counters (
        .clock, .reset,
        .hit_event, .miss_event, .bypass_event,
        .hit_count, .miss_count, .bypass_count
    );

endmodule

// File: run.sh
#!/bin/sh
# Build the icache testbench with Verilator and run it
# The exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module icache_tb \
    -f list.f \
    -o icache_sim \
    && ./obj_dir/icache_sim \
    || exit 1
